/* dekatronPkg.sv */
package dekatronPkg;

    // --------------------------------------------------
    // decimal digit shared by all counter stages
    // --------------------------------------------------
    localparam int dekatronWidth = 4;

    typedef logic [dekatronWidth-1:0] digitT;       // holds 0 to 9 only

    // --------------------------------------------------
    // per-cycle command from a counter to its digits
    // --------------------------------------------------
    typedef struct packed {
        logic step;                                 // move by one this cycle
        logic dec;                                  // count down instead of up
        logic load;                                 // take the parallel value
        logic clear;                                // go to zero, wins over the rest
    } stepCmdT;

endpackage

/* tapePkg.sv */
package tapePkg;

    // --------------------------------------------------
    // APB slave port
    // --------------------------------------------------
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRspT;

    localparam logic [3:0] regCmd    = 4'd0;    // write only
    localparam logic [3:0] regStatus = 4'd4;
    localparam logic [3:0] regAddr   = 4'd8;
    localparam logic [3:0] regData   = 4'd12;

    // --------------------------------------------------
    // tape commands and status
    // --------------------------------------------------
    typedef enum logic [2:0] {
        opNone    = 3'd0,
        opApInc   = 3'd1,
        opApDec   = 3'd2,
        opDataInc = 3'd3,
        opDataDec = 3'd4,
        opClear   = 3'd5
    } cmdOpT;

    typedef struct packed {
        logic apRequest;
        logic dataRequest;
        logic dec;
        logic zero;
    } lineCmdT;

    typedef struct packed {
        logic ready;                            // bit 2 of regStatus
        logic dataZero;
        logic apZero;                           // bit 0 of regStatus
    } statusT;

    localparam int tapeCells = 100;

endpackage

/* DekatronDigit.sv */
`timescale 1ns/1ps

module DekatronDigit (
    input  logic                 Clk,
    input  logic                 Rst_n,
    input  dekatronPkg::stepCmdT cmd,
    input  dekatronPkg::digitT   loadValue,
    output dekatronPkg::digitT   value,
    output logic                 carry
);

    logic atEdge;

    // the digit sits on the value it leaves when it wraps
    assign atEdge = cmd.dec ? (value == 4'd0) : (value == 4'd9);

    // carry or borrow goes out in the same cycle as the wrapping step
    assign carry = cmd.step & ~cmd.load & ~cmd.clear & atEdge;

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            value <= '0;
        end else if (cmd.clear) begin
            value <= '0;
        end else if (cmd.load) begin
            value <= loadValue;
        end else if (cmd.step) begin
            if (atEdge) begin
                value <= cmd.dec ? 4'd9 : 4'd0;     // wrap 0 to 9 or 9 to 0
            end else if (cmd.dec) begin
                value <= value - 4'd1;
            end else begin
                value <= value + 4'd1;
            end
        end
    end

endmodule

/* DekatronCollector.sv */
`timescale 1ns/1ps

module DekatronCollector #(
    parameter int dNum = 2
) (
    input  logic                            Clk,
    input  logic                            Rst_n,
    input  dekatronPkg::digitT              values [dNum],
    input  logic [dNum-1:0]                 carries,
    input  logic                            stepping,
    output dekatronPkg::digitT [dNum-1:0]   word,
    output logic                            zero,
    output logic                            done
);

    // digit 0 ends up in the low bits of the word
    always_comb begin
        for (int i = 0; i < dNum; i++) begin
            word[i] = values[i];
        end
    end

    assign zero = (word == '0);

    // a cycle with a step running and no carry left means the ripple has died out
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            done <= 1'b0;
        end else begin
            done <= stepping && (carries == '0);
        end
    end

endmodule

/* DekatronCounter.sv */
`timescale 1ns/1ps

module DekatronCounter #(
    parameter int                                         dNum         = 2,
    parameter bit                                         topLimitMode = 1'b0,
    parameter logic [dNum*dekatronPkg::dekatronWidth-1:0] topValue     = '0
) (
    input  logic                          Clk,
    input  logic                          Rst_n,
    input  logic                          request,
    input  logic                          dec,
    input  logic                          set,
    input  logic                          setZero,
    input  dekatronPkg::digitT [dNum-1:0] in,
    output logic                          ready,
    output dekatronPkg::digitT [dNum-1:0] out,
    output logic                          zero
);

    logic                          busy;
    logic                          decLatch;
    logic                          stepDec;
    logic                          done;
    logic                          overLimit;
    logic                          limitLoad;
    logic [dNum-2:0]               ripple;
    logic [dNum-1:0]               stepIn;
    logic [dNum-1:0]               carries;
    dekatronPkg::digitT [dNum-1:0] limitWord;
    dekatronPkg::digitT            values [dNum];

    // --------------------------------------------------
    // stepping sequencer
    // --------------------------------------------------
    assign stepIn  = {ripple, request};             // digit 0 steps on the request itself
    assign stepDec = request ? dec : decLatch;
    assign ready   = ~busy;

    // the limit is checked once the ripple has settled, BCD compares like binary
    assign overLimit = topLimitMode && (out > topValue);
    assign limitLoad = busy & done & overLimit;
    assign limitWord = decLatch ? topValue : '0;   // below 000 gives the top value

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            busy     <= 1'b0;
            decLatch <= 1'b0;
            ripple   <= '0;
        end else begin
            ripple <= carries[dNum-2:0];            // one digit further per clock
            if (request) begin
                busy     <= 1'b1;
                decLatch <= dec;
            end else if (busy && done) begin
                busy <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // digit chain
    // --------------------------------------------------
    for (genvar i = 0; i < dNum; i++) begin : gDigit
        dekatronPkg::stepCmdT digitCmd;
        dekatronPkg::digitT   digitLoad;

        assign digitCmd.step  = stepIn[i];
        assign digitCmd.dec   = stepDec;
        assign digitCmd.load  = set | limitLoad;
        assign digitCmd.clear = setZero;
        assign digitLoad      = set ? in[i] : limitWord[i];

        DekatronDigit uDigit (
            .Clk       (Clk),
            .Rst_n     (Rst_n),
            .cmd       (digitCmd),
            .loadValue (digitLoad),
            .value     (values[i]),
            .carry     (carries[i])
        );
    end

    DekatronCollector #(
        .dNum (dNum)
    ) uCollector (
        .Clk      (Clk),
        .Rst_n    (Rst_n),
        .values   (values),
        .carries  (carries),
        .stepping (request | busy),
        .word     (out),
        .zero     (zero),
        .done     (done)
    );

endmodule

/* ApLine.sv */
`timescale 1ns/1ps

module ApLine #(
    parameter  int apDigits   = 2,
    parameter  int dataDigits = 3,
    localparam int apW        = apDigits * dekatronPkg::dekatronWidth,
    localparam int dataW      = dataDigits * dekatronPkg::dekatronWidth
) (
    input  logic             Clk,
    input  logic             Rst_n,
    input  tapePkg::lineCmdT cmd,
    output tapePkg::statusT  status,
    output logic [apW-1:0]   address,
    output logic [dataW-1:0] ramDataIn,
    input  logic [dataW-1:0] ramDataOut,
    output logic             ramWe,
    output logic [dataW-1:0] data
);

    localparam logic [3:0] stIdle  = 4'b0001;
    localparam logic [3:0] stLoad  = 4'b0010;
    localparam logic [3:0] stStore = 4'b0100;
    localparam logic [3:0] stCount = 4'b1000;

    logic [3:0] state;
    logic       apReq;
    logic       dataReq;
    logic       dataSet;
    logic       decHold;
    logic       memLock;                    // the data counter owns the current cell
    logic       apReady;
    logic       dataReady;
    logic       dataCtrZero;

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign status.ready    = (state == stIdle) & apReady & dataReady;
    assign status.dataZero = memLock ? dataCtrZero : (ramDataOut == '0);
    assign data            = memLock ? ramDataIn : ramDataOut;

    // --------------------------------------------------
    // counters
    // --------------------------------------------------
    DekatronCounter #(
        .dNum         (apDigits),
        .topLimitMode (1'b0)
    ) uApCounter (
        .Clk     (Clk),
        .Rst_n   (Rst_n),
        .request (apReq),
        .dec     (decHold),
        .set     (1'b0),
        .setZero (cmd.zero),
        .in      ('0),
        .ready   (apReady),
        .out     (address),
        .zero    (status.apZero)
    );

    DekatronCounter #(
        .dNum         (dataDigits),
        .topLimitMode (1'b1),
        .topValue     (dataW'(12'h255))     // cells wrap at 255
    ) uDataCounter (
        .Clk     (Clk),
        .Rst_n   (Rst_n),
        .request (dataReq),
        .dec     (decHold),
        .set     (dataSet),
        .setZero (cmd.zero),
        .in      (ramDataOut),
        .ready   (dataReady),
        .out     (ramDataIn),
        .zero    (dataCtrZero)
    );

    // --------------------------------------------------
    // line control FSM
    // --------------------------------------------------
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            state   <= stIdle;
            apReq   <= 1'b0;
            dataReq <= 1'b0;
            dataSet <= 1'b0;
            decHold <= 1'b0;
            ramWe   <= 1'b0;
            memLock <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    decHold <= cmd.dec;
                    if (cmd.zero) begin
                        memLock <= 1'b1;                // held cell is now 000 at 00
                    end
                    if (cmd.apRequest) begin
                        if (memLock) begin
                            state <= stStore;
                            ramWe <= 1'b1;
                        end else begin
                            state <= stCount;
                            apReq <= 1'b1;
                        end
                    end else if (cmd.dataRequest) begin
                        if (memLock) begin
                            state   <= stCount;
                            dataReq <= 1'b1;
                        end else begin
                            state   <= stLoad;
                            dataSet <= 1'b1;
                        end
                    end
                end
                stLoad: begin
                    dataSet <= 1'b0;
                    memLock <= 1'b1;
                    dataReq <= 1'b1;
                    state   <= stCount;
                end
                stStore: begin
                    ramWe   <= 1'b0;                    // cell written back this cycle
                    memLock <= 1'b0;
                    apReq   <= 1'b1;
                    state   <= stCount;
                end
                stCount: begin
                    apReq   <= 1'b0;
                    dataReq <= 1'b0;
                    if (!apReq && !dataReq && apReady && dataReady) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

/* TapeRam.sv */
`timescale 1ns/1ps

module TapeRam #(
    parameter  int apDigits   = 2,
    parameter  int dataDigits = 3,
    localparam int digitW     = dekatronPkg::dekatronWidth,
    localparam int dataW      = dataDigits * digitW
) (
    input  logic                         Clk,
    input  logic                         Rst_n,
    input  logic [apDigits*digitW-1:0]   address,
    input  logic [dataW-1:0]             writeData,
    input  logic                         we,
    output logic [dataW-1:0]             readData
);

    logic [dataW-1:0] cells [tapePkg::tapeCells];
    int unsigned      row;

    // decimal address to row number, most significant digit first
    always_comb begin
        row = 0;
        for (int i = apDigits - 1; i >= 0; i--) begin
            row = row * 10 + int'(address[i*digitW +: digitW]);
        end
    end

    assign readData = cells[row];

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            for (int i = 0; i < tapePkg::tapeCells; i++) begin
                cells[i] <= '0;                         // blank tape
            end
        end else if (we) begin
            cells[row] <= writeData;
        end
    end

endmodule

/* TapeApbRegs.sv */
`timescale 1ns/1ps

module TapeApbRegs #(
    parameter  int apDigits   = 2,
    parameter  int dataDigits = 3,
    localparam int apW        = apDigits * dekatronPkg::dekatronWidth,
    localparam int dataW      = dataDigits * dekatronPkg::dekatronWidth
) (
    input  logic             Clk,
    input  logic             Rst_n,
    input  tapePkg::apbReqT  apbReq,
    output tapePkg::apbRspT  apbRsp,
    output tapePkg::lineCmdT lineCmd,
    input  tapePkg::statusT  status,
    input  logic [apW-1:0]   address,
    input  logic [dataW-1:0] data
);

    tapePkg::cmdOpT op;
    logic           access;
    logic           knownAddr;
    logic           validOp;
    logic           cmdWrite;
    logic           issue;
    logic [31:0]    readWord;
    logic [31:0]    readReg;

    assign access   = apbReq.psel & apbReq.penable;
    assign op       = tapePkg::cmdOpT'(apbReq.pwdata[2:0]);
    assign validOp  = op inside {tapePkg::opApInc, tapePkg::opApDec, tapePkg::opDataInc,
                                 tapePkg::opDataDec, tapePkg::opClear};
    assign knownAddr = apbReq.paddr inside {tapePkg::regCmd, tapePkg::regStatus,
                                            tapePkg::regAddr, tapePkg::regData};

    // a valid command write waits here until the line is idle
    assign cmdWrite = access & apbReq.pwrite & (apbReq.paddr == tapePkg::regCmd) & validOp;
    assign issue    = cmdWrite & status.ready;

    // --------------------------------------------------
    // command decode, one pulse on the completing edge
    // --------------------------------------------------
    always_comb begin
        lineCmd = '0;
        if (issue) begin
            case (op)
                tapePkg::opApInc:   lineCmd.apRequest = 1'b1;
                tapePkg::opApDec:   lineCmd = '{apRequest: 1'b1, dec: 1'b1, default: 1'b0};
                tapePkg::opDataInc: lineCmd.dataRequest = 1'b1;
                tapePkg::opDataDec: lineCmd = '{dataRequest: 1'b1, dec: 1'b1, default: 1'b0};
                tapePkg::opClear:   lineCmd.zero = 1'b1;
                default:            lineCmd = '0;
            endcase
        end
    end

    // --------------------------------------------------
    // read path, sampled in the setup cycle
    // --------------------------------------------------
    always_comb begin
        case (apbReq.paddr)
            tapePkg::regStatus: readWord = {29'd0, status};
            tapePkg::regAddr:   readWord = 32'(address);     // BCD digits
            tapePkg::regData:   readWord = 32'(data);
            default:            readWord = '0;               // regCmd and holes read zero
        endcase
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            readReg <= '0;
        end else if (apbReq.psel && !apbReq.penable) begin
            readReg <= readWord;
        end
    end

    assign apbRsp.prdata  = (access && !apbReq.pwrite) ? readReg : '0;
    assign apbRsp.pready  = access & ~(cmdWrite & ~status.ready);
    assign apbRsp.pslverr = access & ~knownAddr;

endmodule

/* TapeMachine.sv */
`timescale 1ns/1ps

module TapeMachine #(
    parameter  int apDigits   = 2,
    parameter  int dataDigits = 3,
    localparam int apW        = apDigits * dekatronPkg::dekatronWidth,
    localparam int dataW      = dataDigits * dekatronPkg::dekatronWidth
) (
    input  logic            Clk,
    input  logic            Rst_n,
    input  tapePkg::apbReqT apbReq,
    output tapePkg::apbRspT apbRsp
);

    tapePkg::lineCmdT lineCmd;
    tapePkg::statusT  status;
    logic [apW-1:0]   address;
    logic [dataW-1:0] data;
    logic [dataW-1:0] ramDataIn;
    logic [dataW-1:0] ramDataOut;
    logic             ramWe;

    // --------------------------------------------------
    // host side
    // --------------------------------------------------
    TapeApbRegs #(
        .apDigits   (apDigits),
        .dataDigits (dataDigits)
    ) uRegs (
        .Clk     (Clk),
        .Rst_n   (Rst_n),
        .apbReq  (apbReq),
        .apbRsp  (apbRsp),
        .lineCmd (lineCmd),
        .status  (status),
        .address (address),
        .data    (data)
    );

    // --------------------------------------------------
    // tape side
    // --------------------------------------------------
    ApLine #(
        .apDigits   (apDigits),
        .dataDigits (dataDigits)
    ) uLine (
        .Clk        (Clk),
        .Rst_n      (Rst_n),
        .cmd        (lineCmd),
        .status     (status),
        .address    (address),
        .ramDataIn  (ramDataIn),
        .ramDataOut (ramDataOut),
        .ramWe      (ramWe),
        .data       (data)
    );

    TapeRam #(
        .apDigits   (apDigits),
        .dataDigits (dataDigits)
    ) uRam (
        .Clk       (Clk),
        .Rst_n     (Rst_n),
        .address   (address),
        .writeData (ramDataIn),
        .we        (ramWe),
        .readData  (ramDataOut)
    );

endmodule

/* tbTapeMachine.sv */
`timescale 1ns/1ps

module tbTapeMachine;

    localparam int xferTimeout  = 40;               // clocks for one APB transfer
    localparam int readyTimeout = 40;               // status polls for one command

    logic            Clk;
    logic            Rst_n;
    tapePkg::apbReqT req;
    tapePkg::apbRspT rsp;

    int     errors;
    int     timeouts;
    int     lastWait;                               // access cycles of the last transfer
    integer seed;
    string  testName;

    // the held cell of the tape model lives apart from the RAM cells
    int modelRam [tapePkg::tapeCells];
    int modelPtr;
    bit modelHeld;
    int modelHeldVal;

    TapeMachine #(
        .apDigits   (2),
        .dataDigits (3)
    ) UUT (
        .Clk    (Clk),
        .Rst_n  (Rst_n),
        .apbReq (req),
        .apbRsp (rsp)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // --------------------------------------------------
    // model of the tape
    // --------------------------------------------------
    function automatic int modelData();
        return modelHeld ? modelHeldVal : modelRam[modelPtr];
    endfunction

    task automatic modelApply(input tapePkg::cmdOpT op);
        case (op)
            tapePkg::opApInc, tapePkg::opApDec: begin
                if (modelHeld) begin
                    modelRam[modelPtr] = modelHeldVal;  // write back before the move
                end
                modelHeld = 1'b0;
                if (op == tapePkg::opApInc) begin
                    modelPtr = (modelPtr + 1) % 100;
                end else begin
                    modelPtr = (modelPtr + 99) % 100;
                end
            end
            tapePkg::opDataInc, tapePkg::opDataDec: begin
                if (!modelHeld) begin
                    modelHeldVal = modelRam[modelPtr];
                    modelHeld    = 1'b1;
                end
                if (op == tapePkg::opDataInc) begin
                    modelHeldVal = (modelHeldVal + 1) % 256;
                end else begin
                    modelHeldVal = (modelHeldVal + 255) % 256;
                end
            end
            tapePkg::opClear: begin
                modelPtr     = 0;                   // the old held cell is dropped
                modelHeld    = 1'b1;
                modelHeldVal = 0;
            end
            default: ;
        endcase
    endtask

    function automatic logic [31:0] toBcd(input int v);
        return {20'd0, 4'(v / 100), 4'((v / 10) % 10), 4'(v % 10)};
    endfunction

    // --------------------------------------------------
    // bus tasks and checks
    // --------------------------------------------------
    task automatic checkValue(input string what, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            errors++;
            $display("** Error %s %s: expected %0h, actual %0h", testName, what, expVal, actVal);
        end
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic apbXfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
        int cycles;
        cycles       = 0;
        req.psel     = 1'b1;
        req.penable  = 1'b0;
        req.pwrite   = wr;
        req.paddr    = addr;
        req.pwdata   = wdata;
        @(posedge Clk);
        #1 req.penable = 1'b1;
        @(negedge Clk);
        while (!rsp.pready && cycles < xferTimeout) begin
            @(negedge Clk);
            cycles++;
        end
        rdata    = rsp.prdata;
        err      = rsp.pslverr;
        lastWait = cycles;
        if (!rsp.pready) begin
            timeouts++;
            $display("%s: APB transfer to offset %0d never completed", testName, addr);
        end
        @(posedge Clk);
        #1 req = '0;
    endtask

    task automatic sendCmd(input tapePkg::cmdOpT op);
        logic [31:0] rd;
        logic        err;
        apbXfer(1'b1, tapePkg::regCmd, 32'(op), rd, err);
        checkValue("command pslverr", 32'd0, 32'(err));
        modelApply(op);
    endtask

    task automatic waitReady();
        logic [31:0] rd;
        logic        err;
        int          polls;
        polls = 0;
        apbXfer(1'b0, tapePkg::regStatus, '0, rd, err);
        while (!rd[2] && polls < readyTimeout) begin
            apbXfer(1'b0, tapePkg::regStatus, '0, rd, err);
            polls++;
        end
        if (!rd[2]) begin
            timeouts++;
            $display("%s: the tape line never came back to ready", testName);
        end
    endtask

    task automatic checkRegs();
        logic [31:0] rd;
        logic        err;
        logic [31:0] expStatus;
        waitReady();
        expStatus = {29'd0, 1'b1, modelData() == 0, modelPtr == 0};
        apbXfer(1'b0, tapePkg::regStatus, '0, rd, err);
        checkValue("status", expStatus, rd);
        apbXfer(1'b0, tapePkg::regAddr, '0, rd, err);
        checkValue("address", toBcd(modelPtr), rd);
        apbXfer(1'b0, tapePkg::regData, '0, rd, err);
        checkValue("data", toBcd(modelData()), rd);
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic testReset();
        testName = "reset";
        checkRegs();
    endtask

    task automatic testDataStep();
        testName = "dataStep";
        for (int i = 0; i < 256; i++) begin
            sendCmd(tapePkg::opDataInc);            // passes 099 and 199 on the way
            checkRegs();
        end
        sendCmd(tapePkg::opDataDec);                // 000 down to 255
        checkRegs();
        sendCmd(tapePkg::opDataInc);
        checkRegs();
    endtask

    task automatic testStorage();
        testName = "storage";
        for (int k = 0; k < 4; k++) begin
            sendCmd(tapePkg::opApDec);              // first move wraps 00 to 99
            repeat (3 * k + 1) sendCmd(k[0] ? tapePkg::opDataDec : tapePkg::opDataInc);
            checkRegs();
        end
        for (int k = 0; k < 6; k++) begin
            sendCmd(tapePkg::opApInc);
            checkRegs();
        end
        for (int k = 0; k < 6; k++) begin
            sendCmd(tapePkg::opApDec);              // back over the wrap to the last cell written
            checkRegs();
        end
    endtask

    task automatic testClear();
        logic [31:0] rd;
        logic        err;
        testName = "clear";
        sendCmd(tapePkg::opApInc);
        sendCmd(tapePkg::opDataInc);
        sendCmd(tapePkg::opClear);
        waitReady();
        apbXfer(1'b0, tapePkg::regStatus, '0, rd, err);
        checkValue("status", 32'd7, rd);
        checkRegs();
    endtask

    task automatic testRandomWalk();
        testName = "backPressure";
        sendCmd(tapePkg::opDataInc);
        sendCmd(tapePkg::opDataInc);                // must wait for the step before it
        checkValue("held write", 32'd1, 32'(lastWait > 0));
        testName = "randomWalk";
        for (int i = 0; i < 200; i++) begin
            sendCmd(tapePkg::cmdOpT'($unsigned($random(seed)) % 6));
        end
        checkRegs();
        for (int i = 0; i < tapePkg::tapeCells; i++) begin
            sendCmd(tapePkg::opApInc);              // read the whole tape back
            checkRegs();
        end
    endtask

    task automatic testUnknown();
        logic [31:0] rd;
        logic        err;
        testName = "unknown";
        apbXfer(1'b0, 4'd2, '0, rd, err);
        checkValue("read pslverr", 32'd1, 32'(err));
        checkValue("read data", 32'd0, rd);
        checkValue("read wait", 32'd0, 32'(lastWait));
        apbXfer(1'b1, 4'd6, 32'd1, rd, err);
        checkValue("write pslverr", 32'd1, 32'(err));
        checkValue("write wait", 32'd0, 32'(lastWait));
        sendCmd(tapePkg::opNone);
        checkValue("none wait", 32'd0, 32'(lastWait));
        apbXfer(1'b1, tapePkg::regCmd, 32'd7, rd, err);
        checkValue("bad op pslverr", 32'd0, 32'(err));
        checkValue("bad op wait", 32'd0, 32'(lastWait));
        checkRegs();
    endtask

    initial begin
        req          = '0;
        Rst_n        = 1'b0;
        errors       = 0;
        timeouts     = 0;
        lastWait     = 0;
        seed         = 54;
        testName     = "init";
        modelPtr     = 0;
        modelHeld    = 1'b0;
        modelHeldVal = 0;
        for (int i = 0; i < tapePkg::tapeCells; i++) begin
            modelRam[i] = 0;
        end
        repeat (5) @(posedge Clk);
        #1 Rst_n = 1'b1;

        testReset();
        testDataStep();
        testStorage();
        testClear();
        testRandomWalk();
        testUnknown();

        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
dekatronPkg.sv
tapePkg.sv
DekatronDigit.sv
DekatronCollector.sv
DekatronCounter.sv
ApLine.sv
TapeRam.sv
TapeApbRegs.sv
TapeMachine.sv
tbTapeMachine.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbTapeMachine
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
EXTRA     ?=

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASS" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
